// ==== design/steer_pkg.sv ====
package steer_pkg;

    // ======================================================================
    // widths
    // ======================================================================
    localparam int DATA_W     = 64;
    localparam int PORT_W     = 2;
    localparam int VF_W       = 3;
    localparam int QID_W      = 6;
    localparam int CFG_ADDR_W = 4;
    localparam int CFG_DATA_W = 12;

    localparam int NUM_PORTS = 4;
    localparam int NUM_PFS   = 2;
    localparam int NUM_VFS   = 8;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [PORT_W-1:0]     port_t;
    typedef logic [VF_W-1:0]       vf_t;
    typedef logic [QID_W-1:0]      qid_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [CFG_DATA_W-1:0] cfg_data_t;

    // port codes, bit 1 set means host side
    localparam port_t PORT_CMAC0 = 2'd0;
    localparam port_t PORT_CMAC1 = 2'd1;
    localparam port_t PORT_PF0   = 2'd2;
    localparam port_t PORT_PF1   = 2'd3;

    // ======================================================================
    // configuration address map
    // ======================================================================
    // forwarding entries sit at base + ingress port
    localparam cfg_addr_t CFG_FWD_BASE  = 4'h0;
    localparam cfg_addr_t CFG_DEMUX_SEL = 4'h4;
    localparam cfg_addr_t CFG_QBASE0    = 4'h5;
    localparam cfg_addr_t CFG_QBASE1    = 4'h6;
    localparam cfg_addr_t CFG_VF_TABLE0 = 4'h8;
    localparam cfg_addr_t CFG_VF_TABLE1 = 4'h9;

    // vf table writes: offset in the low bits, vf number from this bit up
    localparam int CFG_VF_LSB = 8;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FORWARD
    } ctrl_state_t;

endpackage

// ==== design/steer_ctrl.sv ====
`timescale 1ns/1ps

module steer_ctrl (
    input  logic clk,
    input  logic rst,

    // ingress stream handshake
    input  logic in_valid,
    input  logic in_last,
    output logic in_ready,

    // strobe for the table lookups
    output logic lookup_en,

    // beat handoff to the egress demux
    output logic fwd_valid,
    input  logic fwd_ready
);

    import steer_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    // a beat moves on this cycle
    logic beat_accept;

    // ======================================================================
    // handshake
    // ======================================================================
    // beats only pass while forwarding
    // in idle and lookup the input is held off
    assign in_ready    = (state == ST_FORWARD) && fwd_ready;
    assign fwd_valid   = (state == ST_FORWARD) && in_valid;
    assign beat_accept = in_valid && in_ready;

    // one cycle strobe, both tables register on it
    assign lookup_en = (state == ST_LOOKUP);

    // ======================================================================
    // next state
    // ======================================================================
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // start of a new packet, port and vf are already stable
                if (in_valid) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                // results are registered at the end of this cycle
                state_next = ST_FORWARD;
            end
            ST_FORWARD: begin
                // packet ends on the accepted last beat
                // the demux may still be draining it, lookup can overlap
                if (beat_accept && in_last) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== design/fwd_table.sv ====
`timescale 1ns/1ps

module fwd_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_valid,
    input  steer_pkg::cfg_addr_t cfg_addr,
    input  steer_pkg::cfg_data_t cfg_data,
    input  logic                lookup_en,
    input  steer_pkg::port_t    in_port,
    output steer_pkg::port_t    egress_next,
    output steer_pkg::port_t    egress_port
);

    import steer_pkg::*;

    // one egress entry per ingress port
    port_t     fwd_entry [NUM_PORTS];
    // redirect bit per cmac, bit index is the cmac index
    logic [1:0] demux_sel;
    port_t     entry;
    cfg_addr_t fwd_off;

    assign fwd_off = cfg_addr - CFG_FWD_BASE;

    // config writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                fwd_entry[i] <= PORT_CMAC0;
            end
            demux_sel <= '0;
        end else if (cfg_valid) begin
            if (cfg_addr >= CFG_FWD_BASE && fwd_off < NUM_PORTS) begin
                fwd_entry[port_t'(fwd_off)] <= cfg_data[PORT_W-1:0];
            end
            if (cfg_addr == CFG_DEMUX_SEL) begin
                demux_sel <= cfg_data[1:0];
            end
        end
    end

    // table read, then redirect cmac-bound traffic to the matching pf
    assign entry = fwd_entry[in_port];

    always_comb begin
        egress_next = entry;
        if (entry == PORT_CMAC0 && demux_sel[0]) begin
            egress_next = PORT_PF0;
        end else if (entry == PORT_CMAC1 && demux_sel[1]) begin
            egress_next = PORT_PF1;
        end
    end

    // result held for the whole packet
    always_ff @(posedge clk) begin
        if (rst) begin
            egress_port <= PORT_CMAC0;
        end else if (lookup_en) begin
            egress_port <= egress_next;
        end
    end

endmodule

// ==== design/hash2qid.sv ====
`timescale 1ns/1ps

module hash2qid (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_valid,
    input  steer_pkg::cfg_addr_t cfg_addr,
    input  steer_pkg::cfg_data_t cfg_data,
    input  logic                 lookup_en,
    input  steer_pkg::port_t     in_port,
    input  steer_pkg::vf_t       in_vf,
    input  steer_pkg::port_t     egress_port,
    output steer_pkg::qid_t      qid,
    output logic                 rss_en
);

    import steer_pkg::*;

    // per pf queue base and vf offset table
    qid_t qbase  [NUM_PFS];
    qid_t vf_tbl [NUM_PFS][NUM_VFS];

    // fields of a vf table write
    vf_t  cfg_vf;
    qid_t cfg_off;

    vf_t  vf_sel;
    qid_t qid_next;
    logic rss_next;

    assign cfg_vf  = cfg_data[CFG_VF_LSB +: VF_W];
    assign cfg_off = cfg_data[QID_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_PFS; p++) begin
                qbase[p] <= '0;
                for (int v = 0; v < NUM_VFS; v++) begin
                    vf_tbl[p][v] <= '0;
                end
            end
        end else if (cfg_valid) begin
            case (cfg_addr)
                CFG_QBASE0:    qbase[0] <= cfg_off;
                CFG_QBASE1:    qbase[1] <= cfg_off;
                CFG_VF_TABLE0: vf_tbl[0][cfg_vf] <= cfg_off;
                CFG_VF_TABLE1: vf_tbl[1][cfg_vf] <= cfg_off;
                default: ;
            endcase
        end
    end

    // cmac ingress has no vf, use entry 0
    assign vf_sel = (in_port == PORT_CMAC0 || in_port == PORT_CMAC1) ? '0 : in_vf;

    // base + offset of the egress pf, zero toward a cmac
    always_comb begin
        qid_next = '0;
        rss_next = 1'b0;
        case (egress_port)
            PORT_PF0: begin
                qid_next = qbase[0] + vf_tbl[0][vf_sel];
                rss_next = 1'b1;
            end
            PORT_PF1: begin
                qid_next = qbase[1] + vf_tbl[1][vf_sel];
                rss_next = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            qid    <= '0;
            rss_en <= 1'b0;
        end else if (lookup_en) begin
            qid    <= qid_next;
            rss_en <= rss_next;
        end
    end

endmodule

// ==== design/egress_demux.sv ====
`timescale 1ns/1ps

module egress_demux (
    input  logic                          clk,
    input  logic                          rst,

    // beat from the control stage
    input  logic                          fwd_valid,
    output logic                          fwd_ready,
    input  steer_pkg::data_t              in_data,
    input  logic                          in_last,
    input  steer_pkg::port_t              egress_port,
    input  steer_pkg::qid_t               qid,
    input  logic                          rss_en,

    // egress side, one valid/ready pair per port
    output logic [steer_pkg::NUM_PORTS-1:0] out_valid,
    input  logic [steer_pkg::NUM_PORTS-1:0] out_ready,
    output steer_pkg::data_t              out_data,
    output logic                          out_last,
    output steer_pkg::qid_t               out_qid,
    output logic                          out_rss_en
);

    import steer_pkg::*;

    // ======================================================================
    // output register
    // ======================================================================
    logic  hold_valid;
    port_t hold_port;
    logic  leaving;
    logic  load;

    // held beat goes out when its own port is ready
    assign leaving   = hold_valid && out_ready[hold_port];
    // take a new beat when empty or emptying this cycle
    assign fwd_ready = !hold_valid || leaving;
    assign load      = fwd_valid && fwd_ready;

    // valid only, payload keeps no reset
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (load) begin
            hold_valid <= 1'b1;
        end else if (leaving) begin
            hold_valid <= 1'b0;
        end
    end

    // beat and its metadata travel together
    // metadata is latched per beat so a new lookup can overlap the drain
    always_ff @(posedge clk) begin
        if (load) begin
            out_data   <= in_data;
            out_last   <= in_last;
            hold_port  <= egress_port;
            out_qid    <= qid;
            out_rss_en <= rss_en;
        end
    end

    // decode the destination into a single valid bit
    always_comb begin
        out_valid = '0;
        if (hold_valid) begin
            out_valid[hold_port] = 1'b1;
        end
    end

endmodule

// ==== design/steer_top.sv ====
`timescale 1ns/1ps

module steer_top (
    input  logic                            clk,
    input  logic                            rst,

    // ingress stream
    input  logic                            in_valid,
    output logic                            in_ready,
    input  steer_pkg::data_t                in_data,
    input  logic                            in_last,
    input  steer_pkg::port_t                in_port,
    input  steer_pkg::vf_t                  in_vf,

    // write-only configuration port
    input  logic                            cfg_valid,
    input  steer_pkg::cfg_addr_t            cfg_addr,
    input  steer_pkg::cfg_data_t            cfg_data,

    // egress ports
    output logic [steer_pkg::NUM_PORTS-1:0] out_valid,
    input  logic [steer_pkg::NUM_PORTS-1:0] out_ready,
    output steer_pkg::data_t                out_data,
    output logic                            out_last,
    output steer_pkg::qid_t                 out_qid,
    output logic                            out_rss_en
);

    import steer_pkg::*;

    logic  lookup_en;
    logic  fwd_valid;
    logic  fwd_ready;
    // next egress feeds the qid unit in the lookup cycle
    port_t egress_next;
    port_t egress_port;
    qid_t  qid;
    logic  rss_en;

    // ======================================================================
    // packet sequencing
    // ======================================================================
    steer_ctrl steer_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .lookup_en (lookup_en),
        .fwd_valid (fwd_valid),
        .fwd_ready (fwd_ready)
    );

    // ======================================================================
    // lookup tables
    // ======================================================================
    fwd_table fwd_table_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_valid   (cfg_valid),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .lookup_en   (lookup_en),
        .in_port     (in_port),
        .egress_next (egress_next),
        .egress_port (egress_port)
    );

    hash2qid hash2qid_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_valid   (cfg_valid),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .lookup_en   (lookup_en),
        .in_port     (in_port),
        .in_vf       (in_vf),
        .egress_port (egress_next),
        .qid         (qid),
        .rss_en      (rss_en)
    );

    // output register and port decode
    egress_demux egress_demux_inst (
        .clk         (clk),
        .rst         (rst),
        .fwd_valid   (fwd_valid),
        .fwd_ready   (fwd_ready),
        .in_data     (in_data),
        .in_last     (in_last),
        .egress_port (egress_port),
        .qid         (qid),
        .rss_en      (rss_en),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_qid     (out_qid),
        .out_rss_en  (out_rss_en)
    );

endmodule

// ==== tb/steer_tb.sv ====
`timescale 1ns/1ps

module steer_tb;

    import steer_pkg::*;

    // expected beat packed as {last, rss_en, qid, data}
    typedef logic [DATA_W+QID_W+1:0] beat_t;

    localparam int NUM_PKTS    = 64;
    localparam int MAX_LEN     = 8;
    // lookup overhead per packet, random stalls slow beats a few times over
    localparam int CYCLE_LIMIT = NUM_PKTS * (MAX_LEN + 4) * 8 + 1000;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    data_t                in_data;
    logic                 in_last;
    port_t                in_port;
    vf_t                  in_vf;
    logic                 cfg_valid;
    cfg_addr_t            cfg_addr;
    cfg_data_t            cfg_data;
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready = '1;
    data_t                out_data;
    logic                 out_last;
    qid_t                 out_qid;
    logic                 out_rss_en;

    integer seed       = 17;
    int     cycles     = 0;
    logic   idle_check = 1'b0;
    logic   stall_en   = 1'b0;

    // reference copies of the configured tables
    port_t      fwd_model [NUM_PORTS];
    logic [1:0] demux_model;
    qid_t       qbase_model [2];
    qid_t       vf_model [2][NUM_VFS];

    // one expected queue per egress port
    beat_t exp_q [NUM_PORTS][$];

    steer_top steer_top_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_port    (in_port),
        .in_vf      (in_vf),
        .cfg_valid  (cfg_valid),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_qid    (out_qid),
        .out_rss_en (out_rss_en)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ======================================================================
    // error handling
    // ======================================================================
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got == want) else begin
            stop_with_error($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, want));
        end
    endtask

    // hung run guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_error("timeout, the run did not finish within the cycle limit");
        end
    end

    // ======================================================================
    // checks
    // ======================================================================
    // pop and compare every beat that leaves a port
    always @(posedge clk) begin : scoreboard
        beat_t want;
        if (!rst) begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (out_valid[k] && out_ready[k]) begin
                    if (exp_q[k].size() == 0) begin
                        stop_with_error($sformatf("unexpected beat left port %0d", k));
                    end else begin
                        want = exp_q[k].pop_front();
                        check_field("out_data", out_data, want[DATA_W-1:0]);
                        check_field("out_qid", out_qid, want[DATA_W +: QID_W]);
                        check_field("out_rss_en", out_rss_en, want[DATA_W+QID_W]);
                        check_field("out_last", out_last, want[DATA_W+QID_W+1]);
                    end
                end
            end
        end
    end

    // a stalled beat keeps its port and payload
    assert property (@(posedge clk) disable iff (rst)
        (|(out_valid & ~out_ready)) |=> $stable(out_valid) && $stable(out_data)
            && $stable(out_last) && $stable(out_qid) && $stable(out_rss_en))
        else stop_with_error("held beat changed before it transferred");

    assert property (@(posedge clk) idle_check |-> (out_valid == '0) && !in_ready)
        else stop_with_error("egress valid or in_ready high with no input after reset");

    // random back-pressure on all ports
    always @(negedge clk) begin
        if (stall_en) begin
            out_ready = $random(seed);
        end else begin
            out_ready = '1;
        end
    end

    // ======================================================================
    // configuration tasks
    // ======================================================================
    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic set_fwd(input port_t ingress, input port_t egress);
        fwd_model[ingress] = egress;
        cfg_write(cfg_addr_t'(CFG_FWD_BASE + ingress), cfg_data_t'(egress));
    endtask

    task automatic set_demux(input logic [1:0] sel);
        demux_model = sel;
        cfg_write(CFG_DEMUX_SEL, cfg_data_t'(sel));
    endtask

    task automatic set_qbase(input int pf, input qid_t base);
        qbase_model[pf] = base;
        cfg_write((pf == 0) ? CFG_QBASE0 : CFG_QBASE1, cfg_data_t'(base));
    endtask

    // vf number above CFG_VF_LSB, offset in the low bits
    task automatic set_vf_offset(input int pf, input vf_t vf, input qid_t off);
        vf_model[pf][vf] = off;
        cfg_write((pf == 0) ? CFG_VF_TABLE0 : CFG_VF_TABLE1,
                  (cfg_data_t'(vf) << CFG_VF_LSB) | cfg_data_t'(off));
    endtask

    // ======================================================================
    // packet driver and reference model
    // ======================================================================
    function automatic int rand_len();
        return ($unsigned($random(seed)) % MAX_LEN) + 1;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    task automatic send_packet(input port_t port, input vf_t vf, input int len);
        port_t egress;
        vf_t   vf_used;
        qid_t  qid;
        logic  rss;
        data_t beat;
        // table entry, then redirect a cmac to the pf of the same index
        egress = fwd_model[port];
        if (egress == PORT_CMAC0 && demux_model[0]) begin
            egress = PORT_PF0;
        end else if (egress == PORT_CMAC1 && demux_model[1]) begin
            egress = PORT_PF1;
        end
        // cmac ingress looks up vf 0
        vf_used = (port == PORT_CMAC0 || port == PORT_CMAC1) ? vf_t'(0) : vf;
        qid = '0;
        rss = 1'b0;
        if (egress == PORT_PF0 || egress == PORT_PF1) begin
            qid = qbase_model[egress[0]] + vf_model[egress[0]][vf_used];
            rss = 1'b1;
        end
        for (int i = 0; i < len; i++) begin
            beat     = {$random(seed), $random(seed)};
            in_valid = 1'b1;
            in_data  = beat;
            in_last  = (i == len - 1);
            in_port  = port;
            in_vf    = vf;
            exp_q[egress].push_back({in_last, rss, qid, beat});
            // hold the beat until the DUT takes it
            do begin
                @(posedge clk);
            end while (!in_ready);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending() != 0) begin
            @(negedge clk);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        in_port   = PORT_CMAC0;
        in_vf     = '0;
        cfg_valid = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        // tables come out of reset as zero
        demux_model = '0;
        for (int p = 0; p < 2; p++) begin
            qbase_model[p] = '0;
            for (int v = 0; v < NUM_VFS; v++) begin
                vf_model[p][v] = '0;
            end
        end
        for (int k = 0; k < NUM_PORTS; k++) begin
            fwd_model[k] = PORT_CMAC0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // quiet outputs with no input
        idle_check = 1'b1;
        repeat (10) @(negedge clk);
        idle_check = 1'b0;

        // every cmac to cmac mapping
        for (int a = 0; a < 2; a++) begin
            for (int b = 0; b < 2; b++) begin
                set_fwd(PORT_CMAC0, port_t'(a));
                set_fwd(PORT_CMAC1, port_t'(b));
                repeat (2) begin
                    send_packet(PORT_CMAC0, '0, rand_len());
                    send_packet(PORT_CMAC1, '0, rand_len());
                end
            end
        end
        wait_drain();

        // demux select steers cmac-bound traffic to the host
        set_fwd(PORT_CMAC0, PORT_CMAC0);
        set_fwd(PORT_CMAC1, PORT_CMAC1);
        set_demux(2'b11);
        send_packet(PORT_CMAC0, '0, rand_len());
        send_packet(PORT_CMAC1, '0, rand_len());
        send_packet(PORT_PF0, 3'd5, rand_len());
        set_demux(2'b01);
        send_packet(PORT_CMAC0, '0, rand_len());
        send_packet(PORT_CMAC1, '0, rand_len());
        set_demux(2'b00);
        wait_drain();

        // queue id from base plus vf offset
        set_qbase(0, 6'd5);
        set_qbase(1, 6'd40);
        for (int v = 0; v < NUM_VFS; v++) begin
            set_vf_offset(0, vf_t'(v), qid_t'(v * 3 + 1));
            set_vf_offset(1, vf_t'(v), qid_t'(v * 2 + 9));
        end
        set_fwd(PORT_PF0, PORT_PF0);
        set_fwd(PORT_PF1, PORT_PF1);
        for (int v = 0; v < NUM_VFS; v++) begin
            send_packet(PORT_PF0, vf_t'(v), rand_len());
            send_packet(PORT_PF1, vf_t'(NUM_VFS - 1 - v), rand_len());
        end
        // crossed pfs use the egress pf tables
        set_fwd(PORT_PF0, PORT_PF1);
        set_fwd(PORT_PF1, PORT_PF0);
        send_packet(PORT_PF0, 3'd2, rand_len());
        send_packet(PORT_PF1, 3'd6, rand_len());
        wait_drain();

        // mixed traffic under random back-pressure
        set_fwd(PORT_CMAC0, PORT_PF1);
        set_fwd(PORT_CMAC1, PORT_CMAC0);
        set_fwd(PORT_PF0, PORT_CMAC1);
        set_fwd(PORT_PF1, PORT_PF0);
        set_demux(2'b10);
        stall_en = 1'b1;
        repeat (24) begin
            send_packet(port_t'($random(seed)), vf_t'($random(seed)), rand_len());
        end
        // only the last beat can still be held, it leaves once all ports are ready
        stall_en = 1'b0;
        repeat (4) @(negedge clk);

        if (pending() != 0) begin
            stop_with_error("expected beats were never seen at the egress ports");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== steer_top.f ====
design/steer_pkg.sv
design/steer_ctrl.sv
design/fwd_table.sv
design/hash2qid.sv
design/egress_demux.sv
design/steer_top.sv
tb/steer_tb.sv

// ==== Bender.yml ====
package:
  name: steer

sources:
  - design/steer_pkg.sv
  - design/steer_ctrl.sv
  - design/fwd_table.sv
  - design/hash2qid.sv
  - design/egress_demux.sv
  - design/steer_top.sv
  - target: simulation
    files:
      - tb/steer_tb.sv
